// ==== rv_alu_pkg.sv ====
`default_nettype none

package rv_alu_pkg;

    // datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int WB_ADDR_W  = 3;
    localparam int SHAMT_W    = $clog2(XLEN);

    localparam logic [XLEN-1:0] INSTR_STEP = 32'd4;

    // 32-bit encodings carry 11 in the two low bits
    localparam logic [1:0] INSTR_FULL = 2'b11;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    // host register map, word offsets
    localparam logic [WB_ADDR_W-1:0] REG_RS1     = 3'd0;
    localparam logic [WB_ADDR_W-1:0] REG_RS2     = 3'd1;
    localparam logic [WB_ADDR_W-1:0] REG_PC      = 3'd2;
    localparam logic [WB_ADDR_W-1:0] REG_INSTR   = 3'd3;
    localparam logic [WB_ADDR_W-1:0] REG_RESULT  = 3'd4;
    localparam logic [WB_ADDR_W-1:0] REG_NEXT_PC = 3'd5;
    localparam logic [WB_ADDR_W-1:0] REG_STATUS  = 3'd6;
    localparam logic [WB_ADDR_W-1:0] REG_RETIRED = 3'd7;

    // status word layout
    localparam int ST_BUSY    = 0;
    localparam int ST_TAKEN   = 1;
    localparam int ST_WRITE   = 2;
    localparam int ST_ILLEGAL = 3;
    localparam int ST_RD_LSB  = 8;

    // major opcodes, instruction bits 6:2
    typedef enum logic [4:0] {
        OPC_OP     = 5'b01100,
        OPC_OP_IMM = 5'b00100,
        OPC_LUI    = 5'b01101,
        OPC_AUIPC  = 5'b00101,
        OPC_BRANCH = 5'b11000,
        OPC_JAL    = 5'b11011,
        OPC_JALR   = 5'b11001
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_LUI, ALU_AUIPC, ALU_JAL, ALU_JALR,
        ALU_ILLEGAL
    } alu_op_e;

    typedef struct packed {
        logic [XLEN-1:0]       value;
        logic [XLEN-1:0]       next_pc;
        logic                  taken;
        logic                  write;
        logic                  illegal;
        logic [REG_ADDR_W-1:0] rd;
    } res_t;

endpackage

`default_nettype wire

// ==== rv_stage_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// decoded instruction, decode to execute
interface dec_if;
    logic                                      valid;
    rv_alu_pkg::alu_op_e                       op;
    logic [rv_alu_pkg::XLEN-1:0]               a;
    logic [rv_alu_pkg::XLEN-1:0]               b;
    logic [rv_alu_pkg::XLEN-1:0]               pc;
    logic [rv_alu_pkg::XLEN-1:0]               imm;
    logic [rv_alu_pkg::REG_ADDR_W-1:0]         rd;

    modport src (output valid, op, a, b, pc, imm, rd);
    modport dst (input  valid, op, a, b, pc, imm, rd);
endinterface

// executed result, execute to capture
interface exe_if;
    logic                                      valid;
    rv_alu_pkg::res_t                          res;

    modport src (output valid, res);
    modport dst (input  valid, res);
endinterface

`default_nettype wire

// ==== rv_wb_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_wb_regs
    import rv_alu_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_wb_cyc,
    input  logic                 i_wb_stb,
    input  logic                 i_wb_we,
    input  logic [WB_ADDR_W-1:0] i_wb_adr,
    input  logic [XLEN-1:0]      i_wb_dat,
    input  res_t                 i_res,
    input  logic [XLEN-1:0]      i_retired,
    input  logic                 i_busy,
    output logic [XLEN-1:0]      o_wb_dat,
    output logic                 o_wb_ack,
    output logic                 o_launch,
    output logic [XLEN-1:0]      o_instr,
    output logic [XLEN-1:0]      o_rs1,
    output logic [XLEN-1:0]      o_rs2,
    output logic [XLEN-1:0]      o_pc
);

    logic            req;
    logic            wr_en;
    logic [XLEN-1:0] status;
    logic [XLEN-1:0] rd_data;

    // new request, ack is low in the cycle after an ack
    assign req   = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign wr_en = req && i_wb_we;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_ack <= 1'b0;
            o_launch <= 1'b0;
        end else begin
            o_wb_ack <= req;
            o_launch <= wr_en && (i_wb_adr == REG_INSTR);
        end
    end

    // operand registers, read-only offsets fall through
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_rs1 <= '0;
            o_rs2 <= '0;
            o_pc  <= '0;
        end else if (wr_en) begin
            case (i_wb_adr)
                REG_RS1: o_rs1 <= i_wb_dat;
                REG_RS2: o_rs2 <= i_wb_dat;
                REG_PC:  o_pc  <= i_wb_dat;
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en && (i_wb_adr == REG_INSTR)) begin
            o_instr <= i_wb_dat;
        end
    end

    always_comb begin
        status                              = '0;
        status[ST_BUSY]                     = i_busy;
        status[ST_TAKEN]                    = i_res.taken;
        status[ST_WRITE]                    = i_res.write;
        status[ST_ILLEGAL]                  = i_res.illegal;
        status[ST_RD_LSB +: REG_ADDR_W]     = i_res.rd;
    end

    // instr offset reads back as zero
    always_comb begin
        case (i_wb_adr)
            REG_RS1:     rd_data = o_rs1;
            REG_RS2:     rd_data = o_rs2;
            REG_PC:      rd_data = o_pc;
            REG_RESULT:  rd_data = i_res.value;
            REG_NEXT_PC: rd_data = i_res.next_pc;
            REG_STATUS:  rd_data = status;
            REG_RETIRED: rd_data = i_retired;
            default:     rd_data = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (req) begin
            o_wb_dat <= rd_data;
        end
    end

    // results hold still while busy is clear
    a_idle_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_busy |=> $stable(i_res) && $stable(i_retired));

endmodule

`default_nettype wire

// ==== rv_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_decode
    import rv_alu_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_launch,
    input  logic [XLEN-1:0] i_instr,
    input  logic [XLEN-1:0] i_rs1,
    input  logic [XLEN-1:0] i_rs2,
    input  logic [XLEN-1:0] i_pc,
    dec_if.src              dec
);

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_u;
    logic [XLEN-1:0]       imm_b;
    logic [XLEN-1:0]       imm_j;
    alu_op_e               op_d;
    logic [XLEN-1:0]       imm_d;
    logic                  use_rs2;
    logic [REG_ADDR_W-1:0] rd_d;

    assign opcode = opcode_e'(i_instr[6:2]);
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{21{i_instr[31]}}, i_instr[30:20]};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    always_comb begin
        op_d    = ALU_ILLEGAL;
        imm_d   = imm_i;
        use_rs2 = 1'b0;
        if (i_instr[1:0] == INSTR_FULL) begin
            case (opcode)
                OPC_OP: begin
                    use_rs2 = 1'b1;
                    case ({funct7, funct3})
                        {F7_BASE, 3'b000}: op_d = ALU_ADD;
                        {F7_ALT,  3'b000}: op_d = ALU_SUB;
                        {F7_BASE, 3'b001}: op_d = ALU_SLL;
                        {F7_BASE, 3'b010}: op_d = ALU_SLT;
                        {F7_BASE, 3'b011}: op_d = ALU_SLTU;
                        {F7_BASE, 3'b100}: op_d = ALU_XOR;
                        {F7_BASE, 3'b101}: op_d = ALU_SRL;
                        {F7_ALT,  3'b101}: op_d = ALU_SRA;
                        {F7_BASE, 3'b110}: op_d = ALU_OR;
                        {F7_BASE, 3'b111}: op_d = ALU_AND;
                        default: ;
                    endcase
                end
                OPC_OP_IMM: begin
                    // shift amount rides in the low bits of imm_i
                    case (funct3)
                        3'b000: op_d = ALU_ADD;
                        3'b010: op_d = ALU_SLT;
                        3'b011: op_d = ALU_SLTU;
                        3'b100: op_d = ALU_XOR;
                        3'b110: op_d = ALU_OR;
                        3'b111: op_d = ALU_AND;
                        3'b001: if (funct7 == F7_BASE) op_d = ALU_SLL;
                        3'b101: begin
                            if (funct7 == F7_BASE) begin
                                op_d = ALU_SRL;
                            end else if (funct7 == F7_ALT) begin
                                op_d = ALU_SRA;
                            end
                        end
                        default: ;
                    endcase
                end
                OPC_BRANCH: begin
                    use_rs2 = 1'b1;
                    imm_d   = imm_b;
                    case (funct3)
                        3'b000: op_d = ALU_BEQ;
                        3'b001: op_d = ALU_BNE;
                        3'b100: op_d = ALU_BLT;
                        3'b101: op_d = ALU_BGE;
                        3'b110: op_d = ALU_BLTU;
                        3'b111: op_d = ALU_BGEU;
                        default: ;
                    endcase
                end
                OPC_LUI: begin
                    op_d  = ALU_LUI;
                    imm_d = imm_u;
                end
                OPC_AUIPC: begin
                    op_d  = ALU_AUIPC;
                    imm_d = imm_u;
                end
                OPC_JAL: begin
                    op_d  = ALU_JAL;
                    imm_d = imm_j;
                end
                OPC_JALR: if (funct3 == 3'b000) op_d = ALU_JALR;
                default: ;
            endcase
        end
    end

    // branches and rejected encodings have no destination
    assign rd_d = (op_d == ALU_ILLEGAL || opcode == OPC_BRANCH) ? '0 : i_instr[11:7];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= i_launch;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_launch) begin
            dec.op  <= op_d;
            dec.a   <= i_rs1;
            dec.b   <= use_rs2 ? i_rs2 : imm_d;
            dec.pc  <= i_pc;
            dec.imm <= imm_d;
            dec.rd  <= rd_d;
        end
    end

endmodule

`default_nettype wire

// ==== rv_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_execute
    import rv_alu_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst,
    dec_if.dst   dec,
    exe_if.src   exe
);

    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    pc_inc;
    logic               lt_s;
    logic               lt_u;
    logic               has_value;
    res_t               res_d;

    assign shamt  = dec.b[SHAMT_W-1:0];
    assign pc_inc = dec.pc + INSTR_STEP;
    assign lt_s   = $signed(dec.a) < $signed(dec.b);
    assign lt_u   = dec.a < dec.b;

    always_comb begin
        res_d         = '0;
        res_d.next_pc = pc_inc;
        res_d.rd      = dec.rd;
        has_value     = 1'b1;
        case (dec.op)
            ALU_ADD:   res_d.value = dec.a + dec.b;
            ALU_SUB:   res_d.value = dec.a - dec.b;
            ALU_SLL:   res_d.value = dec.a << shamt;
            ALU_SRL:   res_d.value = dec.a >> shamt;
            ALU_SRA:   res_d.value = $signed(dec.a) >>> shamt;
            ALU_SLT:   res_d.value = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:  res_d.value = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:   res_d.value = dec.a ^ dec.b;
            ALU_OR:    res_d.value = dec.a | dec.b;
            ALU_AND:   res_d.value = dec.a & dec.b;
            ALU_LUI:   res_d.value = dec.imm;
            ALU_AUIPC: res_d.value = dec.pc + dec.imm;
            ALU_JAL: begin
                res_d.value   = pc_inc;
                res_d.next_pc = dec.pc + dec.imm;
            end
            ALU_JALR: begin
                res_d.value   = pc_inc;
                res_d.next_pc = (dec.a + dec.imm) & ~32'd1;
            end
            ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU: begin
                has_value = 1'b0;
                case (dec.op)
                    ALU_BEQ:  res_d.taken = dec.a == dec.b;
                    ALU_BNE:  res_d.taken = dec.a != dec.b;
                    ALU_BLT:  res_d.taken = lt_s;
                    ALU_BGE:  res_d.taken = !lt_s;
                    ALU_BLTU: res_d.taken = lt_u;
                    default:  res_d.taken = !lt_u;
                endcase
                if (res_d.taken) begin
                    res_d.next_pc = dec.pc + dec.imm;
                end
            end
            default: begin
                has_value     = 1'b0;
                res_d.illegal = 1'b1;
            end
        endcase
        // x0 is never written
        res_d.write = has_value && (dec.rd != '0);
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            exe.valid <= 1'b0;
        end else begin
            exe.valid <= dec.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (dec.valid) begin
            exe.res <= res_d;
        end
    end

    // rejected encodings carry no destination
    a_illegal_no_rd: assert property (@(posedge i_clk) disable iff (i_rst)
        exe.valid && exe.res.illegal |-> exe.res.rd == '0);

endmodule

`default_nettype wire

// ==== rv_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_result
    import rv_alu_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_launch,
    input  logic            i_dec_valid,
    exe_if.dst              exe,
    output res_t            o_res,
    output logic [XLEN-1:0] o_retired,
    output logic            o_busy
);

    // newest result wins, launch order is kept by the pipeline
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_res <= '0;
        end else if (exe.valid) begin
            o_res <= exe.res;
        end
    end

    // only legal instructions retire
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_retired <= '0;
        end else if (exe.valid && !exe.res.illegal) begin
            o_retired <= o_retired + 1'b1;
        end
    end

    // anything between launch and capture
    assign o_busy = i_launch || i_dec_valid || exe.valid;

endmodule

`default_nettype wire

// ==== rv_alu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_alu_top
    import rv_alu_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_wb_cyc,
    input  logic                 i_wb_stb,
    input  logic                 i_wb_we,
    input  logic [WB_ADDR_W-1:0] i_wb_adr,
    input  logic [XLEN-1:0]      i_wb_dat,
    input  logic [XLEN/8-1:0]    i_wb_sel,
    output logic [XLEN-1:0]      o_wb_dat,
    output logic                 o_wb_ack
);

    logic            launch;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] pc;
    res_t            res;
    logic [XLEN-1:0] retired;
    logic            busy;

    dec_if u_dec_if ();
    exe_if u_exe_if ();

    // whole-word writes, i_wb_sel is not decoded
    rv_wb_regs u_rv_wb_regs (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wb_cyc  (i_wb_cyc),
        .i_wb_stb  (i_wb_stb),
        .i_wb_we   (i_wb_we),
        .i_wb_adr  (i_wb_adr),
        .i_wb_dat  (i_wb_dat),
        .i_res     (res),
        .i_retired (retired),
        .i_busy    (busy),
        .o_wb_dat  (o_wb_dat),
        .o_wb_ack  (o_wb_ack),
        .o_launch  (launch),
        .o_instr   (instr),
        .o_rs1     (rs1),
        .o_rs2     (rs2),
        .o_pc      (pc)
    );

    rv_decode u_rv_decode (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_launch (launch),
        .i_instr  (instr),
        .i_rs1    (rs1),
        .i_rs2    (rs2),
        .i_pc     (pc),
        .dec      (u_dec_if.src)
    );

    rv_execute u_rv_execute (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .dec   (u_dec_if.dst),
        .exe   (u_exe_if.src)
    );

    rv_result u_rv_result (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_launch    (launch),
        .i_dec_valid (u_dec_if.valid),
        .exe         (u_exe_if.dst),
        .o_res       (res),
        .o_retired   (retired),
        .o_busy      (busy)
    );

endmodule

`default_nettype wire

// ==== tb_rv_alu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv_alu_top
    import rv_alu_pkg::*;
();

    localparam int ACK_TIMEOUT  = 16;
    localparam int IDLE_TIMEOUT = 12;
    localparam logic [6:0] MAJ_LOAD   = 7'h03;
    localparam logic [6:0] MAJ_SYSTEM = 7'h73;

    typedef struct {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [XLEN-1:0] pc;
        res_t            exp;
    } vec_t;

    logic                 i_clk;
    logic                 i_rst;
    logic                 i_wb_cyc;
    logic                 i_wb_stb;
    logic                 i_wb_we;
    logic [WB_ADDR_W-1:0] i_wb_adr;
    logic [XLEN-1:0]      i_wb_dat;
    logic [XLEN/8-1:0]    i_wb_sel;
    logic [XLEN-1:0]      o_wb_dat;
    logic                 o_wb_ack;

    vec_t vecs[$];
    int   errors = 0;
    bit   hung   = 1'b0;

    rv_alu_top u_rv_alu_top (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .i_wb_sel (i_wb_sel),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // instruction encoders, source fields fixed at x1 and x2
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, OPC_OP, INSTR_FULL};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH, INSTR_FULL};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL, INSTR_FULL};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input opcode_e opc);
        return {imm, rd, opc, INSTR_FULL};
    endfunction

    task automatic add_vec(input logic [31:0] instr, input logic [31:0] rs1,
                           input logic [31:0] rs2, input logic [31:0] pc,
                           input logic [31:0] value, input logic [31:0] next_pc,
                           input logic taken, input logic write, input logic illegal,
                           input logic [4:0] rd);
        vec_t v;
        v.instr           = instr;
        v.rs1             = rs1;
        v.rs2             = rs2;
        v.pc              = pc;
        v.exp.value       = value;
        v.exp.next_pc     = next_pc;
        v.exp.taken       = taken;
        v.exp.write       = write;
        v.exp.illegal     = illegal;
        v.exp.rd          = rd;
        vecs.push_back(v);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [31:0] a;
        logic [31:0] b;
        rnd = 32'hcbc2_63f0;
        // register arithmetic
        add_vec(r_type(F7_BASE, 3'b000, 3), 5, 7, 'h100, 12, 'h104, 0, 1, 0, 3);
        add_vec(r_type(F7_ALT, 3'b000, 3), 5, 7, 'h100, 'hffff_fffe, 'h104, 0, 1, 0, 3);
        add_vec(r_type(F7_BASE, 3'b001, 3), 1, 'h24, 'h100, 'h10, 'h104, 0, 1, 0, 3);
        add_vec(r_type(F7_BASE, 3'b101, 3), 'h8000_0000, 4, 'h100, 'h0800_0000, 'h104,
                0, 1, 0, 3);
        add_vec(r_type(F7_ALT, 3'b101, 3), 'h8000_0000, 4, 'h100, 'hf800_0000, 'h104,
                0, 1, 0, 3);
        add_vec(r_type(F7_BASE, 3'b010, 3), 'hffff_ffff, 1, 'h100, 1, 'h104, 0, 1, 0, 3);
        add_vec(r_type(F7_BASE, 3'b011, 3), 'hffff_ffff, 1, 'h100, 0, 'h104, 0, 1, 0, 3);
        add_vec(r_type(F7_BASE, 3'b100, 3), 'hf0f0_f0f0, 'h0ff0_0ff0, 'h100, 'hff00_ff00,
                'h104, 0, 1, 0, 3);
        add_vec(r_type(F7_BASE, 3'b110, 3), 'hf0f0_f0f0, 'h0ff0_0ff0, 'h100, 'hfff0_fff0,
                'h104, 0, 1, 0, 3);
        add_vec(r_type(F7_BASE, 3'b111, 3), 'hf0f0_f0f0, 'h0ff0_0ff0, 'h100, 'h00f0_00f0,
                'h104, 0, 1, 0, 3);
        // x0 destination keeps the value but drops the write
        add_vec(r_type(F7_BASE, 3'b000, 0), 1, 2, 'h100, 3, 'h104, 0, 0, 0, 0);
        // immediate forms, rs2 must be ignored
        add_vec(i_type('hffd, 3'b000, 4, 7'h13), 10, 'hdead_beef, 'h100, 7, 'h104, 0, 1, 0, 4);
        add_vec(i_type('hfff, 3'b010, 4, 7'h13), 'hffff_fffe, 0, 'h100, 1, 'h104, 0, 1, 0, 4);
        add_vec(i_type('hfff, 3'b011, 4, 7'h13), 5, 0, 'h100, 1, 'h104, 0, 1, 0, 4);
        add_vec(i_type('h0ff, 3'b100, 4, 7'h13), 'h0f0f_0f0f, 0, 'h100, 'h0f0f_0ff0, 'h104,
                0, 1, 0, 4);
        add_vec(i_type('h004, 3'b001, 4, 7'h13), 3, 0, 'h100, 'h30, 'h104, 0, 1, 0, 4);
        add_vec(i_type('h004, 3'b101, 4, 7'h13), 'h8000_0010, 0, 'h100, 'h0800_0001, 'h104,
                0, 1, 0, 4);
        add_vec(i_type('h404, 3'b101, 4, 7'h13), 'h8000_0010, 0, 'h100, 'hf800_0001, 'h104,
                0, 1, 0, 4);
        // random operands, expected from the RV32I rules
        repeat (2) begin
            rnd = xorshift32(rnd);
            a   = rnd;
            rnd = xorshift32(rnd);
            b   = rnd;
            add_vec(r_type(F7_BASE, 3'b000, 7), a, b, 'h100, a + b, 'h104, 0, 1, 0, 7);
            add_vec(r_type(F7_ALT, 3'b000, 7), a, b, 'h100, a - b, 'h104, 0, 1, 0, 7);
            add_vec(r_type(F7_BASE, 3'b100, 7), a, b, 'h100, a ^ b, 'h104, 0, 1, 0, 7);
            add_vec(r_type(F7_BASE, 3'b011, 7), a, b, 'h100, {31'b0, a < b}, 'h104,
                    0, 1, 0, 7);
        end
        add_vec(u_type('h12345, 5, OPC_LUI), 0, 0, 'h100, 'h1234_5000, 'h104, 0, 1, 0, 5);
        add_vec(u_type('h00001, 6, OPC_AUIPC), 0, 0, 'h1000, 'h2000, 'h1004, 0, 1, 0, 6);
        add_vec(u_type('hfffff, 6, OPC_AUIPC), 0, 0, 'h1000, 0, 'h1004, 0, 1, 0, 6);
        // branches, one taken and one not taken each
        add_vec(b_type('h010, 3'b000), 5, 5, 'h200, 0, 'h210, 1, 0, 0, 0);
        add_vec(b_type('h010, 3'b000), 5, 6, 'h200, 0, 'h204, 0, 0, 0, 0);
        add_vec(b_type('h010, 3'b001), 5, 6, 'h200, 0, 'h210, 1, 0, 0, 0);
        add_vec(b_type('h010, 3'b001), 5, 5, 'h200, 0, 'h204, 0, 0, 0, 0);
        add_vec(b_type('h1ff8, 3'b100), 'hffff_ffff, 1, 'h200, 0, 'h1f8, 1, 0, 0, 0);
        add_vec(b_type('h1ff8, 3'b100), 1, 'hffff_ffff, 'h200, 0, 'h204, 0, 0, 0, 0);
        add_vec(b_type('h010, 3'b101), 1, 'hffff_ffff, 'h200, 0, 'h210, 1, 0, 0, 0);
        add_vec(b_type('h010, 3'b101), 'hffff_ffff, 1, 'h200, 0, 'h204, 0, 0, 0, 0);
        add_vec(b_type('h010, 3'b110), 1, 'hffff_ffff, 'h200, 0, 'h210, 1, 0, 0, 0);
        add_vec(b_type('h010, 3'b110), 'hffff_ffff, 1, 'h200, 0, 'h204, 0, 0, 0, 0);
        add_vec(b_type('h1ff8, 3'b111), 'hffff_ffff, 1, 'h200, 0, 'h1f8, 1, 0, 0, 0);
        add_vec(b_type('h1ff8, 3'b111), 1, 'hffff_ffff, 'h200, 0, 'h204, 0, 0, 0, 0);
        // jumps
        add_vec(j_type('h000800, 1), 0, 0, 'h300, 'h304, 'hb00, 0, 1, 0, 1);
        add_vec(j_type('h1fff00, 1), 0, 0, 'h300, 'h304, 'h200, 0, 1, 0, 1);
        add_vec(j_type('h000800, 0), 0, 0, 'h300, 'h304, 'hb00, 0, 0, 0, 0);
        add_vec(i_type('h004, 3'b000, 1, 7'h67), 'h1001, 0, 'h400, 'h404, 'h1004, 0, 1, 0, 1);
        add_vec(i_type('hfff, 3'b000, 1, 7'h67), 'h2000, 0, 'h400, 'h404, 'h1ffe, 0, 1, 0, 1);
        // load, csr, compressed and mul are all rejected
        add_vec(i_type('h010, 3'b010, 3, MAJ_LOAD), 1, 2, 'h500, 0, 'h504, 0, 0, 1, 0);
        add_vec(i_type('h300, 3'b001, 3, MAJ_SYSTEM), 1, 2, 'h500, 0, 'h504, 0, 0, 1, 0);
        add_vec(32'h0000_4501, 1, 2, 'h500, 0, 'h504, 0, 0, 1, 0);
        add_vec(r_type(7'h01, 3'b000, 3), 1, 2, 'h500, 0, 'h504, 0, 0, 1, 0);
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // busy must be clear once the result is read
    task automatic check_status(input string name, input res_t exp,
                                input logic [XLEN-1:0] act);
        logic [XLEN-1:0] exp_st;
        exp_st                            = '0;
        exp_st[ST_TAKEN]                  = exp.taken;
        exp_st[ST_WRITE]                  = exp.write;
        exp_st[ST_ILLEGAL]                = exp.illegal;
        exp_st[ST_RD_LSB +: REG_ADDR_W]   = exp.rd;
        check_word(name, exp_st, act);
    endtask

    // starts and ends 10 ns after a rising edge
    task automatic wb_access(input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [XLEN-1:0] wdat, output logic [XLEN-1:0] rdat);
        int cycles;
        bit acked;
        cycles = 0;
        acked  = 1'b0;
        rdat   = '0;
        if (!hung) begin
            i_wb_cyc = 1'b1;
            i_wb_stb = 1'b1;
            i_wb_we  = we;
            i_wb_adr = adr;
            i_wb_dat = wdat;
            while (!acked && cycles < ACK_TIMEOUT) begin
                @(posedge i_clk);
                #10;
                cycles++;
                acked = o_wb_ack;
            end
            rdat     = o_wb_dat;
            i_wb_cyc = 1'b0;
            i_wb_stb = 1'b0;
            i_wb_we  = 1'b0;
            if (!acked) begin
                hung = 1'b1;
                $display("no ack from the DUT for offset %0d by %0t", adr, $time);
            end
        end
    endtask

    task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [XLEN-1:0] dat);
        logic [XLEN-1:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [WB_ADDR_W-1:0] adr, output logic [XLEN-1:0] dat);
        wb_access(1'b0, adr, '0, dat);
    endtask

    task automatic wait_idle();
        logic [XLEN-1:0] st;
        int polls;
        polls = 0;
        st    = '1;
        while (!hung && st[ST_BUSY] && polls < IDLE_TIMEOUT) begin
            wb_read(REG_STATUS, st);
            polls++;
        end
        if (!hung && st[ST_BUSY]) begin
            hung = 1'b1;
            $display("busy never cleared after launch, gave up at %0t", $time);
        end
    endtask

    initial begin
        logic [XLEN-1:0] rdat;
        logic [XLEN-1:0] exp_retired;
        string tag;
        i_rst       = 1'b1;
        i_wb_cyc    = 1'b0;
        i_wb_stb    = 1'b0;
        i_wb_we     = 1'b0;
        i_wb_adr    = '0;
        i_wb_dat    = '0;
        i_wb_sel    = '1;
        exp_retired = '0;
        repeat (5) @(posedge i_clk);
        #10;
        i_rst = 1'b0;

        // reset values, then read-only offsets ignore writes
        for (int a = 0; a < 8; a++) begin
            wb_read(a[WB_ADDR_W-1:0], rdat);
            check_word($sformatf("reset reg%0d", a), '0, rdat);
        end
        for (int a = REG_RESULT; a <= REG_RETIRED; a++) begin
            wb_write(a[WB_ADDR_W-1:0], 32'hffff_ffff);
            wb_read(a[WB_ADDR_W-1:0], rdat);
            check_word($sformatf("read-only reg%0d", a), '0, rdat);
        end
        wb_write(REG_RS1, 32'h1357_9bdf);
        wb_write(REG_RS2, 32'h2468_ace0);
        wb_write(REG_PC, 32'h0000_0abc);
        wb_read(REG_RS1, rdat);
        check_word("rs1 readback", 32'h1357_9bdf, rdat);
        wb_read(REG_RS2, rdat);
        check_word("rs2 readback", 32'h2468_ace0, rdat);
        wb_read(REG_PC, rdat);
        check_word("pc readback", 32'h0000_0abc, rdat);

        build_table();
        foreach (vecs[i]) begin
            wb_write(REG_RS1, vecs[i].rs1);
            wb_write(REG_RS2, vecs[i].rs2);
            wb_write(REG_PC, vecs[i].pc);
            wb_write(REG_INSTR, vecs[i].instr);
            wait_idle();
            if (hung) break;
            if (!vecs[i].exp.illegal) exp_retired++;
            tag = $sformatf("vec%0d", i);
            wb_read(REG_RESULT, rdat);
            check_word({tag, " result"}, vecs[i].exp.value, rdat);
            wb_read(REG_NEXT_PC, rdat);
            check_word({tag, " next_pc"}, vecs[i].exp.next_pc, rdat);
            wb_read(REG_STATUS, rdat);
            check_status({tag, " status"}, vecs[i].exp, rdat);
            wb_read(REG_RETIRED, rdat);
            check_word({tag, " retired"}, exp_retired, rdat);
        end

        $display("run complete: %0d value errors, %0d timeouts", errors, hung);
        if (errors == 0 && !hung) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rv_alu_pkg.sv
rv_stage_if.sv
rv_wb_regs.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_alu_top.sv
tb_rv_alu_top.sv

// ==== Bender.yml ====
package:
  name: rv_alu

sources:
  - rv_alu_pkg.sv
  - rv_stage_if.sv
  - rv_wb_regs.sv
  - rv_decode.sv
  - rv_execute.sv
  - rv_result.sv
  - rv_alu_top.sv
  - target: test
    files:
      - tb_rv_alu_top.sv
